//--- common/led_matrix_pkg.sv
// HUB75 LED matrix driver shared definitions
// panel geometry, pixel format, scan timing and UART settings
`default_nettype none

package led_matrix_pkg;

    // panel geometry, two halves of 8 row addresses
    localparam int num_cols      = 8;
    localparam int num_row_addrs = 8;
    localparam int num_rows      = 16;
    localparam int bit_depth     = 4;   // bits per color channel

    typedef logic [2:0] col_t;
    typedef logic [2:0] row_addr_t;
    typedef logic [1:0] plane_t;
    typedef logic [6:0] fb_addr_t;      // row * num_cols + col

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } pixel_t;

    typedef struct packed {
        logic red;
        logic green;
        logic blue;
    } rgb_t;

    // scan timing in clk_root cycles
    localparam int pixel_step_ticks = 4;
    localparam int base_on_ticks    = 16;   // plane 0, doubles per plane
    localparam int blank_ticks      = 2;

    typedef logic [$clog2(pixel_step_ticks)-1:0] step_phase_t;

    // host serial line
    localparam int uart_ticks_per_bit = 8;
    localparam int cmd_start_bit      = 7;  // set on address bytes

    typedef logic [$clog2(uart_ticks_per_bit)-1:0] uart_tick_t;

endpackage

`default_nettype wire

//--- common/scan_if.sv
// scan position and fetch strobe from the scan FSM to the pixel fetch path
`timescale 1ns/10ps
`default_nettype none

interface scan_if;

    led_matrix_pkg::col_t      col;         // column to fetch, valid with fetch_start
    led_matrix_pkg::row_addr_t row_addr;
    led_matrix_pkg::plane_t    plane;
    logic                      fetch_start; // one pulse per column step

    modport fsm (
        output col, row_addr, plane, fetch_start
    );

    modport fetch (
        input col, row_addr, plane, fetch_start
    );

endinterface

`default_nettype wire

//--- hdl/uart_rx.sv
// UART receiver, 8N1, LSB first
// pulses byte_valid for one clock per byte with a good stop bit
`timescale 1ns/10ps
`default_nettype none

module uart_rx (
    input  wire logic       clk_root,
    input  wire logic       rst_n,
    input  wire logic       rxd,
    output logic      [7:0] rx_byte,
    output logic            byte_valid
);

    typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_t;

    state_t                   state;
    logic [1:0]               rxd_sync;     // two-flop synchronizer
    led_matrix_pkg::uart_tick_t tick;
    logic [2:0]               bit_cnt;
    logic [7:0]               shreg;

    assign rx_byte = shreg;

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            rxd_sync   <= 2'b11;   // line idles high
            state      <= st_idle;
            tick       <= '0;
            bit_cnt    <= '0;
            byte_valid <= 1'b0;
        end else begin
            rxd_sync   <= {rxd_sync[0], rxd};
            byte_valid <= 1'b0;
            if (state != st_idle) begin
                tick <= tick - 1'b1;
            end
            case (state)
                st_idle: if (!rxd_sync[1]) begin
                    // wait half a bit to land mid start bit
                    tick  <= led_matrix_pkg::uart_tick_t'(led_matrix_pkg::uart_ticks_per_bit / 2 - 1);
                    state <= st_start;
                end
                st_start: if (tick == '0) begin
                    tick    <= led_matrix_pkg::uart_tick_t'(led_matrix_pkg::uart_ticks_per_bit - 1);
                    bit_cnt <= '0;
                    state   <= rxd_sync[1] ? st_idle : st_data;   // glitch, back to idle
                end
                st_data: if (tick == '0) begin
                    shreg   <= {rxd_sync[1], shreg[7:1]};
                    tick    <= led_matrix_pkg::uart_tick_t'(led_matrix_pkg::uart_ticks_per_bit - 1);
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 3'd7) begin
                        state <= st_stop;
                    end
                end
                st_stop: if (tick == '0) begin
                    byte_valid <= rxd_sync[1];   // framing error drops the byte
                    state      <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/cmd_decoder.sv
// host command decoder
// address byte plus two data bytes make one framebuffer write
`timescale 1ns/10ps
`default_nettype none

module cmd_decoder (
    input  wire logic                     clk_root,
    input  wire logic                     rst_n,
    input  wire logic [7:0]               rx_byte,
    input  wire logic                     byte_valid,
    output logic                          wr_en,
    output led_matrix_pkg::fb_addr_t      wr_addr,
    output led_matrix_pkg::pixel_t        wr_data
);

    typedef enum logic [1:0] {st_idle, st_have_addr, st_have_hi} state_t;

    state_t                   state;
    led_matrix_pkg::fb_addr_t pend_addr;
    logic [5:0]               pend_hi;      // pixel bits 11..6

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            state <= st_idle;
            wr_en <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            if (byte_valid) begin
                if (rx_byte[led_matrix_pkg::cmd_start_bit]) begin
                    // address byte always restarts a command
                    pend_addr <= led_matrix_pkg::fb_addr_t'(rx_byte[6:0]);
                    state     <= st_have_addr;
                end else begin
                    case (state)
                        st_have_addr: begin
                            pend_hi <= rx_byte[5:0];
                            state   <= st_have_hi;
                        end
                        st_have_hi: begin
                            wr_addr <= pend_addr;
                            wr_data <= led_matrix_pkg::pixel_t'({pend_hi, rx_byte[5:0]});
                            wr_en   <= 1'b1;
                            state   <= st_idle;
                        end
                        default: ;  // stray data byte
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/frame_buffer.sv
// framebuffer, simple dual-port RAM, one pixel per word
// port A writes from the host, port B reads for the scan with one clock latency
`timescale 1ns/10ps
`default_nettype none

module frame_buffer (
    input  wire logic                     clk_root,
    input  wire logic                     wr_en,
    input  wire led_matrix_pkg::fb_addr_t wr_addr,
    input  wire led_matrix_pkg::pixel_t   wr_data,
    input  wire led_matrix_pkg::fb_addr_t rd_addr,
    output led_matrix_pkg::pixel_t        rd_data
);

    led_matrix_pkg::pixel_t mem [led_matrix_pkg::num_rows * led_matrix_pkg::num_cols];

    always_ff @(posedge clk_root) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk_root) begin
        rd_data <= mem[rd_addr];   // registered read
    end

endmodule

`default_nettype wire

//--- led_scan/scan_timer.sv
// scan timer, loadable down-counter
// done pulses load_value clocks after the load, then the counter idles
`timescale 1ns/10ps
`default_nettype none

module scan_timer (
    input  wire logic       clk_root,
    input  wire logic       rst_n,
    input  wire logic       load,
    input  wire logic [7:0] load_value,
    output logic            done
);

    logic [7:0] count;
    logic       active;

    assign done = active && (count == '0);

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            count  <= '0;
            active <= 1'b0;
        end else if (load) begin
            count  <= load_value - 8'd1;   // zero lands on the last timed cycle
            active <= 1'b1;
        end else if (active) begin
            if (count == '0) begin
                active <= 1'b0;
            end else begin
                count <= count - 8'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- led_scan/scan_fsm.sv
// scan sequencer, per plane: shift 8 columns, blank, latch, display
// display time doubles with each bit plane, row advances after the last plane
`timescale 1ns/10ps
`default_nettype none

module scan_fsm (
    input  wire logic       clk_root,
    input  wire logic       rst_n,
    scan_if.fsm             scan,
    output logic            timer_load,
    output logic      [7:0] timer_value,
    input  wire logic       timer_done,
    output logic            pix_clk,
    output logic            latch,
    output logic            oe_n
);

    typedef enum logic [2:0] {st_prep, st_shift, st_blank, st_latch, st_display} state_t;

    state_t                        state;
    led_matrix_pkg::col_t          col;        // column being shifted
    led_matrix_pkg::row_addr_t     row;
    led_matrix_pkg::plane_t        plane;
    led_matrix_pkg::step_phase_t   phase;      // position inside a column step
    logic                          last_col;

    assign last_col = (col == led_matrix_pkg::col_t'(led_matrix_pkg::num_cols - 1));

    // fetch runs one cycle ahead of each step, so the next column goes out here
    assign scan.fetch_start = (state == st_prep) || (state == st_shift && timer_done && !last_col);
    assign scan.col         = (state == st_shift) ? col + 1'b1 : col;
    assign scan.row_addr    = row;
    assign scan.plane       = plane;

    assign pix_clk = (state == st_shift) &&
                     (phase >= led_matrix_pkg::step_phase_t'(led_matrix_pkg::pixel_step_ticks - 2));
    assign latch   = (state == st_latch);
    assign oe_n    = (state != st_display);

    // timer is loaded in the last cycle of the state before the one it times
    always_comb begin
        timer_load  = 1'b0;
        timer_value = 8'(led_matrix_pkg::pixel_step_ticks);
        case (state)
            st_prep:  timer_load = 1'b1;
            st_shift: if (timer_done) begin
                timer_load = 1'b1;
                if (last_col) begin
                    timer_value = 8'(led_matrix_pkg::blank_ticks);
                end
            end
            st_latch: begin
                timer_load  = 1'b1;
                timer_value = 8'(led_matrix_pkg::base_on_ticks) << plane;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            state <= st_prep;
            col   <= '0;
            row   <= '0;
            plane <= '0;
            phase <= '0;
        end else begin
            case (state)
                st_prep: begin
                    phase <= '0;
                    state <= st_shift;
                end
                st_shift: begin
                    phase <= phase + 1'b1;
                    if (timer_done) begin
                        phase <= '0;
                        col   <= last_col ? '0 : col + 1'b1;
                        if (last_col) begin
                            state <= st_blank;
                        end
                    end
                end
                st_blank: if (timer_done) state <= st_latch;
                st_latch: state <= st_display;
                st_display: if (timer_done) begin
                    // row and plane move while outputs are off
                    state <= st_prep;
                    if (plane == led_matrix_pkg::plane_t'(led_matrix_pkg::bit_depth - 1)) begin
                        plane <= '0;
                        row   <= row + 1'b1;   // wraps after 7
                    end else begin
                        plane <= plane + 1'b1;
                    end
                end
                default: state <= st_prep;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- led_scan/pixel_fetch.sv
// pixel fetch, reads the top and bottom pixel of a column
// and drives the color bits of the current bit plane
`timescale 1ns/10ps
`default_nettype none

module pixel_fetch (
    input  wire logic                     clk_root,
    input  wire logic                     rst_n,
    scan_if.fetch                         scan,
    output led_matrix_pkg::fb_addr_t      rd_addr,
    input  wire led_matrix_pkg::pixel_t   rd_data,
    output led_matrix_pkg::rgb_t          rgb_top,
    output led_matrix_pkg::rgb_t          rgb_bottom
);

    led_matrix_pkg::row_addr_t fetch_row;
    led_matrix_pkg::col_t      fetch_col;
    led_matrix_pkg::plane_t    fetch_plane;
    led_matrix_pkg::pixel_t    top_pix;
    logic                      stage1;     // top pixel on rd_data
    logic                      stage2;     // bottom pixel on rd_data

    function automatic led_matrix_pkg::fb_addr_t pix_addr(
        input led_matrix_pkg::row_addr_t row,
        input led_matrix_pkg::col_t      col,
        input logic                      bottom
    );
        int unsigned panel_row;
        panel_row = row + (bottom ? led_matrix_pkg::num_row_addrs : 0);
        return led_matrix_pkg::fb_addr_t'(panel_row * led_matrix_pkg::num_cols + col);
    endfunction

    function automatic led_matrix_pkg::rgb_t plane_bits(
        input led_matrix_pkg::pixel_t pix,
        input led_matrix_pkg::plane_t pl
    );
        return '{red: pix.red[pl], green: pix.green[pl], blue: pix.blue[pl]};
    endfunction

    // top address with the strobe, bottom one a cycle later
    assign rd_addr = scan.fetch_start ? pix_addr(scan.row_addr, scan.col, 1'b0)
                                      : pix_addr(fetch_row, fetch_col, 1'b1);

    always_ff @(posedge clk_root) begin
        if (scan.fetch_start) begin
            fetch_row   <= scan.row_addr;
            fetch_col   <= scan.col;
            fetch_plane <= scan.plane;
        end
        if (stage1) begin
            top_pix <= rd_data;
        end
    end

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            stage1     <= 1'b0;
            stage2     <= 1'b0;
            rgb_top    <= '0;
            rgb_bottom <= '0;
        end else begin
            stage1 <= scan.fetch_start;
            stage2 <= stage1;
            if (stage2) begin
                rgb_top    <= plane_bits(top_pix, fetch_plane);   // both halves change together
                rgb_bottom <= plane_bits(rd_data, fetch_plane);
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/hub75_driver.sv
// HUB75 driver top, 8x16 panel with 4-bit BCM color
// UART upload into the framebuffer, scan out on the panel pins
`timescale 1ns/10ps
`default_nettype none

module hub75_driver (
    input  wire logic                       clk_root,
    input  wire logic                       rst_n,
    input  wire logic                       uart_rxd,
    output logic                            pix_clk,
    output logic                            latch,
    output logic                            oe_n,
    output led_matrix_pkg::row_addr_t       row_addr,
    output led_matrix_pkg::rgb_t            rgb_top,
    output led_matrix_pkg::rgb_t            rgb_bottom
);

    logic [7:0]               rx_byte;
    logic                     byte_valid;
    logic                     wr_en;
    led_matrix_pkg::fb_addr_t wr_addr;
    led_matrix_pkg::pixel_t   wr_data;
    led_matrix_pkg::fb_addr_t rd_addr;
    led_matrix_pkg::pixel_t   rd_data;
    logic                     timer_load;
    logic [7:0]               timer_value;
    logic                     timer_done;

    scan_if scan ();

    assign row_addr = scan.row_addr;

    uart_rx u_uart_rx (.clk_root, .rst_n, .rxd(uart_rxd), .rx_byte, .byte_valid);

    cmd_decoder u_cmd_decoder (.clk_root, .rst_n, .rx_byte, .byte_valid,
                               .wr_en, .wr_addr, .wr_data);

    frame_buffer u_frame_buffer (.clk_root, .wr_en, .wr_addr, .wr_data, .rd_addr, .rd_data);

    scan_timer u_scan_timer (.clk_root, .rst_n, .load(timer_load),
                             .load_value(timer_value), .done(timer_done));

    scan_fsm u_scan_fsm (.clk_root, .rst_n, .scan(scan.fsm), .timer_load, .timer_value,
                         .timer_done, .pix_clk, .latch, .oe_n);

    pixel_fetch u_pixel_fetch (.clk_root, .rst_n, .scan(scan.fetch), .rd_addr, .rd_data,
                               .rgb_top, .rgb_bottom);

endmodule

`default_nettype wire

//--- verification/hub75_driver_chk.sv
// panel control checks for the HUB75 driver, bound into the top level
`timescale 1ns/10ps
`default_nettype none

module hub75_driver_chk (
    input wire logic                      clk_root,
    input wire logic                      rst_n,
    input wire logic                      pix_clk,
    input wire logic                      latch,
    input wire logic                      oe_n,
    input wire led_matrix_pkg::row_addr_t row_addr
);

    int unsigned fail_count = 0;

    // latch only with the outputs off
    latch_while_blank: assert property (@(posedge clk_root) disable iff (!rst_n)
        latch |-> oe_n)
        else begin
            $error("latch high while oe_n low");
            fail_count++;
        end

    no_clock_in_latch: assert property (@(posedge clk_root) disable iff (!rst_n)
        latch |-> !pix_clk)
        else begin
            $error("pix_clk high during latch");
            fail_count++;
        end

    // row may only move while the panel is dark
    row_held_on_display: assert property (@(posedge clk_root) disable iff (!rst_n)
        !oe_n |-> $stable(row_addr))
        else begin
            $error("row_addr changed while oe_n low");
            fail_count++;
        end

endmodule

bind hub75_driver hub75_driver_chk chk (.clk_root, .rst_n, .pix_clk, .latch, .oe_n, .row_addr);

`default_nettype wire

//--- verification/hub75_driver_tb.sv
// HUB75 driver testbench
// uploads pixels over the UART and checks scan timing and panel data per plane
`timescale 1ns/10ps
`default_nettype none

module hub75_driver_tb;

    localparam int clk_half     = 20;
    localparam int num_pixels   = led_matrix_pkg::num_rows * led_matrix_pkg::num_cols;
    localparam int half_offset  = led_matrix_pkg::num_row_addrs * led_matrix_pkg::num_cols;
    localparam int num_planes   = led_matrix_pkg::num_row_addrs * led_matrix_pkg::bit_depth;
    localparam int plane_cycles = led_matrix_pkg::num_cols * led_matrix_pkg::pixel_step_ticks
                                  + led_matrix_pkg::blank_ticks + 2;
    localparam int frame_cycles = led_matrix_pkg::num_row_addrs *
        (led_matrix_pkg::bit_depth * plane_cycles +
         led_matrix_pkg::base_on_ticks * (2 ** led_matrix_pkg::bit_depth - 1));
    localparam int byte_cycles  = 10 * led_matrix_pkg::uart_ticks_per_bit;
    // each frame check may first wait up to a frame and a row for row 0
    localparam int watchdog_cycles = 3 * 3 * frame_cycles
                                     + (3 * num_pixels + 16) * byte_cycles + 100;

    logic                      clk_root;
    logic                      rst_n;
    logic                      uart_rxd;
    logic                      pix_clk;
    logic                      latch;
    logic                      oe_n;
    led_matrix_pkg::row_addr_t row_addr;
    led_matrix_pkg::rgb_t      rgb_top;
    led_matrix_pkg::rgb_t      rgb_bottom;

    led_matrix_pkg::pixel_t    model [num_pixels];   // expected framebuffer
    int                        mismatches;

    hub75_driver uut (.clk_root, .rst_n, .uart_rxd, .pix_clk, .latch, .oe_n,
                      .row_addr, .rgb_top, .rgb_bottom);

    task automatic compare_rgb(input string name, input led_matrix_pkg::rgb_t got,
                               input led_matrix_pkg::rgb_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic compare_row(input string name, input led_matrix_pkg::row_addr_t got,
                               input led_matrix_pkg::row_addr_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        if (got != exp) begin
            mismatches++;
            $display("MISMATCH %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic compare_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    // one color bit per channel of the given plane
    function automatic led_matrix_pkg::rgb_t expected_color(input led_matrix_pkg::pixel_t pix,
                                                            input int k);
        led_matrix_pkg::rgb_t bits;
        bits.red   = pix.red[k];
        bits.green = pix.green[k];
        bits.blue  = pix.blue[k];
        return bits;
    endfunction

    // 8N1 frame sent LSB first from a falling edge
    task automatic send_byte(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            uart_rxd = frame[i];
            repeat (led_matrix_pkg::uart_ticks_per_bit) @(negedge clk_root);
        end
    endtask

    task automatic write_pixel(input led_matrix_pkg::fb_addr_t addr,
                               input led_matrix_pkg::pixel_t pix);
        send_byte({1'b1, addr});
        send_byte({2'b00, pix[11:6]});
        send_byte({2'b00, pix[5:0]});
        model[addr] = pix;
    endtask

    // one full frame from row 0 plane 0 with timing and optional color checks
    task automatic observe_frame(input bit check_pixels);
        int                        displays;
        int                        edges;
        int                        low_cycles;
        int                        plane;
        int                        top_addr;
        led_matrix_pkg::row_addr_t row;
        logic                      prev_pix;
        logic                      prev_oe;
        do begin
            @(negedge clk_root);
        end while (row_addr !== 3'd7);
        do begin
            @(negedge clk_root);
        end while (row_addr !== 3'd0);
        displays   = 0;
        edges      = 0;
        low_cycles = 0;
        plane      = 0;
        row        = 3'd0;
        prev_pix   = pix_clk;
        prev_oe    = oe_n;
        while (displays < num_planes) begin
            @(negedge clk_root);
            if (pix_clk && !prev_pix) begin
                if (check_pixels && edges < led_matrix_pkg::num_cols) begin
                    top_addr = int'(row) * led_matrix_pkg::num_cols + edges;
                    compare_rgb("rgb_top", rgb_top, expected_color(model[top_addr], plane));
                    compare_rgb("rgb_bottom", rgb_bottom,
                                expected_color(model[top_addr + half_offset], plane));
                end
                edges++;
            end
            if (latch) begin
                compare_count("pix_clk edges per latch", edges, led_matrix_pkg::num_cols);
                compare_row("row_addr", row_addr, row);
                edges = 0;
            end
            if (!oe_n) begin
                low_cycles++;
            end
            if (oe_n && !prev_oe) begin   // display just ended
                compare_count("oe_n low time", low_cycles,
                              led_matrix_pkg::base_on_ticks * (2 ** plane));
                low_cycles = 0;
                displays++;
                if (plane == led_matrix_pkg::bit_depth - 1) begin
                    plane = 0;
                    row   = row + 1'b1;   // wraps after 7
                end else begin
                    plane++;
                end
            end
            prev_pix = pix_clk;
            prev_oe  = oe_n;
        end
    endtask

    task automatic reset_state();
        for (int i = 0; i < 6; i++) begin
            @(negedge clk_root);
            compare_level("oe_n", oe_n, 1'b1);
            compare_level("latch", latch, 1'b0);
            compare_level("pix_clk", pix_clk, 1'b0);
            if (i == 4) begin
                rst_n = 1'b1;
            end
        end
        compare_row("row_addr", row_addr, 3'd0);
    endtask

    task automatic scan_timing();
        observe_frame(1'b0);   // framebuffer still unwritten
    endtask

    task automatic random_image();
        led_matrix_pkg::pixel_t pix;
        for (int a = 0; a < num_pixels; a++) begin
            pix = 12'($urandom());
            write_pixel(led_matrix_pkg::fb_addr_t'(a), pix);
        end
        observe_frame(1'b1);
    endtask

    task automatic stray_bytes();
        led_matrix_pkg::fb_addr_t good_addr;
        led_matrix_pkg::fb_addr_t cut_addr;
        led_matrix_pkg::pixel_t   pix;
        good_addr = 7'($urandom());
        cut_addr  = good_addr + 7'd1;
        send_byte(8'h15);                      // no address pending
        send_byte({1'b1, cut_addr});
        send_byte({2'b00, 6'($urandom())});    // cut short by the next address
        pix = ~model[good_addr];
        write_pixel(good_addr, pix);
        observe_frame(1'b1);
    endtask

    initial begin
        clk_root = 1'b0;
        forever #clk_half clk_root = ~clk_root;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk_root);
        $display("timeout: tests did not finish within %0d clock cycles", watchdog_cycles);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        uart_rxd   = 1'b1;   // line idle
        mismatches = 0;
        void'($urandom(64));
        reset_state();
        scan_timing();
        random_image();
        stray_bytes();
        $display("errors: %0d mismatches, %0d assertion failures",
                 mismatches, uut.chk.fail_count);
        if (mismatches == 0 && uut.chk.fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hub75_driver.f
common/led_matrix_pkg.sv
common/scan_if.sv
hdl/uart_rx.sv
hdl/cmd_decoder.sv
hdl/frame_buffer.sv
led_scan/scan_timer.sv
led_scan/scan_fsm.sv
led_scan/pixel_fetch.sv
hdl/hub75_driver.sv
verification/hub75_driver_chk.sv
verification/hub75_driver_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= hub75_driver_tb
FILELIST  ?= hub75_driver.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@grep -q "Simulation passed" $(LOG) || { echo "FAIL: run did not complete"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
